//--- src/ccu_pkg.sv
// Shared sizes, config word layout and enums; NUM_PE must stay a power of two for res_sel
`default_nettype none

package ccu_pkg;

    // ================================================
    // Array and datapath sizes
    // ================================================
    localparam int NUM_PE         = 4;
    localparam int PE_IDX_W       = 2;
    localparam int DATA_W         = 16;
    localparam int CFG_W          = 16;
    localparam int LEN_W          = 8;

    // FIFO depth of 8 words
    localparam int FIFO_DEPTH_LOG = 3;
    localparam int FIFO_DEPTH     = 1 << FIFO_DEPTH_LOG;

    // ================================================
    // Config word layout
    // ================================================
    // Target PE index
    localparam int CFG_IDX_MSB    = 15;
    localparam int CFG_IDX_LSB    = 14;
    // Opcode field
    localparam int CFG_OP_MSB     = 13;
    localparam int CFG_OP_LSB     = 12;
    // Sample count, bits 11..8 unused
    localparam int CFG_LEN_MSB    = 7;
    localparam int CFG_LEN_LSB    = 0;

    // PE fold operations
    typedef enum logic [1:0] {
        OP_ADD = 2'b00,
        OP_SUB = 2'b01,
        OP_MAX = 2'b10,
        OP_XOR = 2'b11
    } pe_op_e;

    // Control unit phases
    typedef enum logic [1:0] {
        CCU_IDLE = 2'b00,
        CCU_CFG  = 2'b01,
        CCU_CMP  = 2'b10
    } ccu_state_e;

endpackage

`default_nettype wire

//--- src/cfg_fifo.sv
// Single-clock FIFO; push while full and pop while empty are dropped, data_out valid after pop
`timescale 1ns/1ps
`default_nettype none

module cfg_fifo (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         push,
    input  wire                         pop,
    input  wire  [ccu_pkg::CFG_W-1:0]   data_in,
    output logic [ccu_pkg::CFG_W-1:0]   data_out,
    output logic                        empty,
    output logic                        full
);

    // Extra MSB on pointers tells full from empty
    logic [ccu_pkg::FIFO_DEPTH_LOG:0]   wr_ptr;
    logic [ccu_pkg::FIFO_DEPTH_LOG:0]   rd_ptr;
    logic [ccu_pkg::CFG_W-1:0]          mem [ccu_pkg::FIFO_DEPTH];
    logic                               do_push;
    logic                               do_pop;

    // Qualified strobes
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // Same address, MSB differs when wrapped
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[ccu_pkg::FIFO_DEPTH_LOG] != rd_ptr[ccu_pkg::FIFO_DEPTH_LOG]) &&
                   (wr_ptr[ccu_pkg::FIFO_DEPTH_LOG-1:0] == rd_ptr[ccu_pkg::FIFO_DEPTH_LOG-1:0]);

    // ================================================
    // Pointers
    // ================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // ================================================
    // Storage and read register
    // ================================================
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[ccu_pkg::FIFO_DEPTH_LOG-1:0]] <= data_in;
        end
        // Word lands one cycle after pop
        if (do_pop) begin
            data_out <= mem[rd_ptr[ccu_pkg::FIFO_DEPTH_LOG-1:0]];
        end
    end

endmodule

`default_nettype wire

//--- src/ccu.sv
// Control FSM; start only taken in IDLE, CFG drains the whole FIFO before compute begins
`timescale 1ns/1ps
`default_nettype none

module ccu (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         start,
    input  wire                         fifo_empty,
    input  wire  [ccu_pkg::NUM_PE-1:0]  pe_finished,
    output logic                        fifo_pop,
    output logic                        cfg_wr,
    output logic                        cfg_clr,
    output logic                        cmp_start,
    output logic                        busy,
    output logic                        done
);

    ccu_pkg::ccu_state_e state;
    ccu_pkg::ccu_state_e state_nxt;
    logic                all_finished;

    assign all_finished = &pe_finished;

    // ================================================
    // Phase strobes
    // ================================================
    // Wipe old config as the run is accepted
    assign cfg_clr   = (state == ccu_pkg::CCU_IDLE) && start;

    // One word per cycle while anything is queued
    assign fifo_pop  = (state == ccu_pkg::CCU_CFG) && !fifo_empty;

    // Last CFG cycle, FIFO dry and last word already written
    // PEs clear on the edge into CMP
    assign cmp_start = (state == ccu_pkg::CCU_CFG) && fifo_empty && !cfg_wr;

    // High through CFG and CMP
    assign busy      = (state != ccu_pkg::CCU_IDLE);

    // ================================================
    // Next state
    // ================================================
    always_comb begin
        state_nxt = state;
        case (state)
            ccu_pkg::CCU_IDLE: begin
                if (start) begin
                    state_nxt = ccu_pkg::CCU_CFG;
                end
            end
            ccu_pkg::CCU_CFG: begin
                if (cmp_start) begin
                    state_nxt = ccu_pkg::CCU_CMP;
                end
            end
            ccu_pkg::CCU_CMP: begin
                // Every PE has folded its share
                if (all_finished) begin
                    state_nxt = ccu_pkg::CCU_IDLE;
                end
            end
            default: begin
                state_nxt = ccu_pkg::CCU_IDLE;
            end
        endcase
    end

    // ================================================
    // State and registered strobes
    // ================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= ccu_pkg::CCU_IDLE;
            cfg_wr <= 1'b0;
            done   <= 1'b0;
        end else begin
            state  <= state_nxt;
            // Write follows pop by one cycle, matches FIFO read latency
            cfg_wr <= fifo_pop;
            // Single pulse, same cycle busy drops
            done   <= (state == ccu_pkg::CCU_CMP) && all_finished;
        end
    end

endmodule

`default_nettype wire

//--- src/pe_cfg_regs.sv
// Per-PE opcode and length bank; a later word for the same PE overwrites, clear has priority
`timescale 1ns/1ps
`default_nettype none

module pe_cfg_regs (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         cfg_clr,
    input  wire                         cfg_wr,
    input  wire  [ccu_pkg::CFG_W-1:0]   cfg_word,
    output ccu_pkg::pe_op_e             pe_op [ccu_pkg::NUM_PE],
    output logic [ccu_pkg::LEN_W-1:0]   pe_len [ccu_pkg::NUM_PE]
);

    // ================================================
    // Field decode
    // ================================================
    logic [ccu_pkg::PE_IDX_W-1:0]   wr_idx;
    ccu_pkg::pe_op_e                wr_op;
    logic [ccu_pkg::LEN_W-1:0]      wr_len;

    assign wr_idx = cfg_word[ccu_pkg::CFG_IDX_MSB:ccu_pkg::CFG_IDX_LSB];
    assign wr_op  = ccu_pkg::pe_op_e'(cfg_word[ccu_pkg::CFG_OP_MSB:ccu_pkg::CFG_OP_LSB]);
    assign wr_len = cfg_word[ccu_pkg::CFG_LEN_MSB:ccu_pkg::CFG_LEN_LSB];

    // ================================================
    // Register bank
    // ================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < ccu_pkg::NUM_PE; i++) begin
                pe_op[i]  <= ccu_pkg::OP_ADD;
                pe_len[i] <= '0;
            end
        end else if (cfg_clr) begin
            // Zero length so unconfigured PEs finish at once with 0
            for (int i = 0; i < ccu_pkg::NUM_PE; i++) begin
                pe_op[i]  <= ccu_pkg::OP_ADD;
                pe_len[i] <= '0;
            end
        end else if (cfg_wr) begin
            // Only the addressed PE is touched
            for (int i = 0; i < ccu_pkg::NUM_PE; i++) begin
                if (wr_idx == ccu_pkg::PE_IDX_W'(i)) begin
                    pe_op[i]  <= wr_op;
                    pe_len[i] <= wr_len;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- src/pe_block.sv
// One PE; op and len must stay steady during compute, samples ignored once finished
`timescale 1ns/1ps
`default_nettype none

module pe_block (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         cmp_start,
    input  wire                         smp_val,
    input  wire  [ccu_pkg::DATA_W-1:0]  smp_data,
    input  ccu_pkg::pe_op_e             op,
    input  wire  [ccu_pkg::LEN_W-1:0]   len,
    output logic [ccu_pkg::DATA_W-1:0]  acc,
    output logic                        finished
);

    logic [ccu_pkg::LEN_W-1:0]  cnt;
    logic [ccu_pkg::LEN_W-1:0]  cnt_nxt;
    logic [ccu_pkg::DATA_W-1:0] acc_nxt;
    logic                       take;

    // Sample consumed only while still counting
    assign take    = smp_val && !finished;
    assign cnt_nxt = cnt + 1'b1;

    // ================================================
    // Fold operation
    // ================================================
    always_comb begin
        acc_nxt = acc;
        case (op)
            // Wraps modulo 2^DATA_W
            ccu_pkg::OP_ADD: acc_nxt = acc + smp_data;
            // Accumulator minus sample, wraps too
            ccu_pkg::OP_SUB: acc_nxt = acc - smp_data;
            // Unsigned compare
            ccu_pkg::OP_MAX: acc_nxt = (smp_data > acc) ? smp_data : acc;
            ccu_pkg::OP_XOR: acc_nxt = acc ^ smp_data;
        endcase
    end

    // ================================================
    // Counter, accumulator, finished flag
    // ================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // Idle PEs sit finished so stray samples are dropped
            cnt      <= '0;
            acc      <= '0;
            finished <= 1'b1;
        end else if (cmp_start) begin
            cnt      <= '0;
            acc      <= '0;
            // Zero length finishes straight away
            finished <= (len == '0);
        end else if (take) begin
            cnt <= cnt_nxt;
            acc <= acc_nxt;
            // Flag visible the cycle after the last sample
            if (cnt_nxt == len) begin
                finished <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/pe_array_top.sv
// Top level; res_data valid after done until the next start, pushes in CFG drain in that run
`timescale 1ns/1ps
`default_nettype none

module pe_array_top (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire                             cfg_push,
    input  wire  [ccu_pkg::CFG_W-1:0]       cfg_data,
    output logic                            cfg_full,
    input  wire                             start,
    input  wire                             smp_val,
    input  wire  [ccu_pkg::DATA_W-1:0]      smp_data,
    output logic                            busy,
    output logic                            done,
    input  wire  [ccu_pkg::PE_IDX_W-1:0]    res_sel,
    output logic [ccu_pkg::DATA_W-1:0]      res_data
);

    // ================================================
    // Internal nets
    // ================================================
    logic                           fifo_pop;
    logic                           cfg_empty;
    logic [ccu_pkg::CFG_W-1:0]      fifo_dout;
    logic                           cfg_wr;
    logic                           cfg_clr;
    logic                           cmp_start;
    logic [ccu_pkg::NUM_PE-1:0]     pe_finished;
    ccu_pkg::pe_op_e                pe_op [ccu_pkg::NUM_PE];
    logic [ccu_pkg::LEN_W-1:0]      pe_len [ccu_pkg::NUM_PE];
    logic [ccu_pkg::DATA_W-1:0]     pe_acc [ccu_pkg::NUM_PE];

    // Host config queue
    cfg_fifo cfg_fifo_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (cfg_push),
        .pop      (fifo_pop),
        .data_in  (cfg_data),
        .data_out (fifo_dout),
        .empty    (cfg_empty),
        .full     (cfg_full)
    );

    // Phase control
    ccu ccu_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .fifo_empty  (cfg_empty),
        .pe_finished (pe_finished),
        .fifo_pop    (fifo_pop),
        .cfg_wr      (cfg_wr),
        .cfg_clr     (cfg_clr),
        .cmp_start   (cmp_start),
        .busy        (busy),
        .done        (done)
    );

    // FIFO word lands here with cfg_wr
    pe_cfg_regs pe_cfg_regs_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .cfg_clr  (cfg_clr),
        .cfg_wr   (cfg_wr),
        .cfg_word (fifo_dout),
        .pe_op    (pe_op),
        .pe_len   (pe_len)
    );

    // ================================================
    // PE array, samples broadcast to all
    // ================================================
    for (genvar g = 0; g < ccu_pkg::NUM_PE; g++) begin : g_pe
        pe_block pe_block_i (
            .clk       (clk),
            .rst_n     (rst_n),
            .cmp_start (cmp_start),
            .smp_val   (smp_val),
            .smp_data  (smp_data),
            .op        (pe_op[g]),
            .len       (pe_len[g]),
            .acc       (pe_acc[g]),
            .finished  (pe_finished[g])
        );
    end

    // Result readback, purely combinational
    assign res_data = pe_acc[res_sel];

endmodule

`default_nettype wire

//--- testbench/tb_clk_gen.sv
// Clock runs from time zero with a 20 ns period; rst_n is released on a falling edge after 4 cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    localparam int HALF_PERIOD_NS = 10;
    localparam int RESET_CYCLES   = 4;

    // Free-running clock
    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD_NS) clk = ~clk;
    end

    // Release away from the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- testbench/tb_checker.sv
// Samples DUT pins on the rising edge; expected values arrive from tb_top with res_chk and full_chk
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          start,
    input  wire                          busy,
    input  wire                          done,
    input  wire                          cfg_full,
    input  wire  [ccu_pkg::PE_IDX_W-1:0] res_sel,
    input  wire  [ccu_pkg::DATA_W-1:0]   res_data,
    input  wire                          res_chk,
    input  wire  [ccu_pkg::DATA_W-1:0]   exp_data,
    input  wire                          full_chk,
    input  wire                          exp_full,
    output int                           errors,
    output int                           checks,
    output int                           done_count
);

    logic prev_busy;
    logic prev_done;
    logic start_taken;
    logic after_reset;

    task automatic flag(input string msg);
        errors++;
        $display("[ERROR] %0t: %s", $time, msg);
    endtask

    initial begin
        errors      = 0;
        checks      = 0;
        done_count  = 0;
        prev_busy   = 1'b0;
        prev_done   = 1'b0;
        start_taken = 1'b0;
        after_reset = 1'b0;
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            after_reset = 1'b1;
            prev_busy   = 1'b0;
            prev_done   = 1'b0;
            start_taken = 1'b0;
        end else begin
            // ================================================
            // Control protocol
            // ================================================
            // First cycle out of reset, everything quiet
            if (after_reset) begin
                checks++;
                if (busy !== 1'b0 || done !== 1'b0 || cfg_full !== 1'b0) begin
                    flag("busy, done or cfg_full not low after reset");
                end
                after_reset = 1'b0;
            end
            if (start_taken && busy !== 1'b1) begin
                flag("busy not raised the cycle after start");
            end
            if (done) begin
                done_count++;
                checks++;
                if (prev_done) flag("done held longer than one cycle");
                if (!prev_busy) flag("done without busy in the cycle before");
                if (busy) flag("busy still high in the done cycle");
            end
            // Busy only drops together with done
            if (prev_busy && !busy && !done) begin
                flag("busy fell without a done pulse");
            end

            // ================================================
            // Values posted by the model
            // ================================================
            if (res_chk) begin
                checks++;
                if (res_data !== exp_data) begin
                    flag($sformatf("PE %0d result %h, expected %h", res_sel, res_data, exp_data));
                end
            end
            if (full_chk) begin
                checks++;
                if (cfg_full !== exp_full) begin
                    flag($sformatf("cfg_full %b, expected %b", cfg_full, exp_full));
                end
            end
            start_taken = start && !busy;
            prev_busy   = busy;
            prev_done   = done;
        end
    end

endmodule

`default_nettype wire

//--- testbench/tb_top.sv
// Fixed-seed LFSR stimulus on falling edges; samples only go out once the compute phase has begun
`timescale 1ns/1ps
`default_nettype none

module tb_top;

    localparam int NUM_TESTS       = 5;
    localparam int RUNS_PER_TEST   = 6;
    localparam int RUN_LIMIT       = 600;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * RUNS_PER_TEST * RUN_LIMIT;

    logic                           clk;
    logic                           rst_n;
    logic                           cfg_push;
    logic [ccu_pkg::CFG_W-1:0]      cfg_data;
    logic                           cfg_full;
    logic                           start;
    logic                           smp_val;
    logic [ccu_pkg::DATA_W-1:0]     smp_data;
    logic                           busy;
    logic                           done;
    logic [ccu_pkg::PE_IDX_W-1:0]   res_sel;
    logic [ccu_pkg::DATA_W-1:0]     res_data;
    // Expected values for the checker
    logic                           res_chk;
    logic [ccu_pkg::DATA_W-1:0]     exp_data;
    logic                           full_chk;
    logic                           exp_full;
    int                             chk_errors;
    int                             chk_checks;
    int                             done_count;
    // Reference model state
    logic [15:0]                    lfsr_q;
    logic [ccu_pkg::CFG_W-1:0]      word_q [$];
    logic [ccu_pkg::DATA_W-1:0]     smp_q [$];
    ccu_pkg::pe_op_e                model_op [ccu_pkg::NUM_PE];
    int                             model_len [ccu_pkg::NUM_PE];
    int                             tb_errors;
    int                             runs;

    tb_clk_gen clk_gen_i (.clk(clk), .rst_n(rst_n));

    pe_array_top dut_i (
        .clk(clk), .rst_n(rst_n), .cfg_push(cfg_push), .cfg_data(cfg_data),
        .cfg_full(cfg_full), .start(start), .smp_val(smp_val), .smp_data(smp_data),
        .busy(busy), .done(done), .res_sel(res_sel), .res_data(res_data)
    );

    tb_checker checker_i (
        .clk(clk), .rst_n(rst_n), .start(start), .busy(busy), .done(done),
        .cfg_full(cfg_full), .res_sel(res_sel), .res_data(res_data), .res_chk(res_chk),
        .exp_data(exp_data), .full_chk(full_chk), .exp_full(exp_full),
        .errors(chk_errors), .checks(chk_checks), .done_count(done_count)
    );

    // ================================================
    // Random source and reference model
    // ================================================
    // Fibonacci LFSR x^16+x^14+x^13+x^11+1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            r      = {r[30:0], fb};
        end
        return r;
    endfunction

    // Unused bits 11..8 carry random junk
    function automatic logic [ccu_pkg::CFG_W-1:0] make_word(input int idx, input int op,
                                                            input int len);
        logic [ccu_pkg::CFG_W-1:0] w;
        w = ccu_pkg::CFG_W'(rand_bits(ccu_pkg::CFG_W));
        w[ccu_pkg::CFG_IDX_MSB:ccu_pkg::CFG_IDX_LSB] = ccu_pkg::PE_IDX_W'(idx);
        w[ccu_pkg::CFG_OP_MSB:ccu_pkg::CFG_OP_LSB]   = 2'(op);
        w[ccu_pkg::CFG_LEN_MSB:ccu_pkg::CFG_LEN_LSB] = ccu_pkg::LEN_W'(len);
        return w;
    endfunction

    function automatic logic [15:0] fold(input ccu_pkg::pe_op_e op, input logic [15:0] acc,
                                         input logic [15:0] s);
        case (op)
            ccu_pkg::OP_ADD: return acc + s;
            ccu_pkg::OP_SUB: return acc - s;
            ccu_pkg::OP_MAX: return (acc >= s) ? acc : s;
            default:         return acc ^ s;
        endcase
    endfunction

    // First len valid samples of the run
    function automatic logic [15:0] model_result(input int p);
        logic [15:0] acc;
        acc = '0;
        for (int i = 0; i < model_len[p] && i < smp_q.size(); i++) begin
            acc = fold(model_op[p], acc, smp_q[i]);
        end
        return acc;
    endfunction

    // Clear first and then apply queued words in push order
    task automatic load_model();
        logic [ccu_pkg::CFG_W-1:0] w;
        int                        idx;
        for (int p = 0; p < ccu_pkg::NUM_PE; p++) begin
            model_op[p]  = ccu_pkg::OP_ADD;
            model_len[p] = 0;
        end
        while (word_q.size() > 0) begin
            w              = word_q.pop_front();
            idx            = int'(w[ccu_pkg::CFG_IDX_MSB:ccu_pkg::CFG_IDX_LSB]);
            model_op[idx]  = ccu_pkg::pe_op_e'(w[ccu_pkg::CFG_OP_MSB:ccu_pkg::CFG_OP_LSB]);
            model_len[idx] = int'(w[ccu_pkg::CFG_LEN_MSB:ccu_pkg::CFG_LEN_LSB]);
        end
    endtask

    // ================================================
    // Stimulus tasks
    // ================================================
    task automatic push_word(input logic [ccu_pkg::CFG_W-1:0] w);
        @(negedge clk);
        cfg_push = 1'b1;
        cfg_data = w;
        // Model queue holds eight and later words are lost
        if (word_q.size() < ccu_pkg::FIFO_DEPTH) word_q.push_back(w);
        @(negedge clk);
        cfg_push = 1'b0;
        exp_full = (word_q.size() == ccu_pkg::FIFO_DEPTH);
        full_chk = 1'b1;
        @(negedge clk);
        full_chk = 1'b0;
    endtask

    task automatic do_run(input bit poke_start);
        int cyc;
        int n;
        int need;
        int sent;
        int n_due;
        bit seen_done;
        @(negedge clk);
        start = 1'b1;
        load_model();
        smp_q.delete();
        @(negedge clk);
        start = 1'b0;
        cyc   = 0;
        // Longest configured length decides when done is due
        need  = 0;
        for (int p = 0; p < ccu_pkg::NUM_PE; p++) begin
            if (model_len[p] > need) need = model_len[p];
        end
        // CFG length follows the number of queued words
        while (dut_i.cmp_start !== 1'b1 && cyc < RUN_LIMIT) begin
            @(negedge clk);
            cyc++;
        end
        seen_done = 1'b0;
        n         = 0;
        sent      = 0;
        // Done shows two cycles after the last needed sample goes out
        n_due     = (need == 0) ? 2 : 0;
        while (!seen_done && cyc < RUN_LIMIT) begin
            @(negedge clk);
            cyc++;
            n++;
            seen_done = done;
            // Stray start in mid-compute that the DUT must ignore
            start     = poke_start && (n == 4) && !done;
            smp_val   = !done && (rand_bits(2) != 0);
            smp_data  = ccu_pkg::DATA_W'(rand_bits(ccu_pkg::DATA_W));
            if (smp_val) begin
                smp_q.push_back(smp_data);
                sent++;
                if (sent == need) n_due = n + 2;
            end
        end
        smp_val = 1'b0;
        start   = 1'b0;
        if (!seen_done) begin
            $display("Run %0d got no done pulse within %0d cycles", runs, RUN_LIMIT);
            tb_errors++;
        end else if (n != n_due) begin
            $display("[ERROR] %0t: run %0d done in compute cycle %0d, expected cycle %0d",
                     $time, runs, n, n_due);
            tb_errors++;
        end
        // Read back every PE
        for (int p = 0; p < ccu_pkg::NUM_PE; p++) begin
            @(negedge clk);
            res_sel  = ccu_pkg::PE_IDX_W'(p);
            exp_data = model_result(p);
            res_chk  = 1'b1;
        end
        @(negedge clk);
        res_chk = 1'b0;
        runs++;
    endtask

    task automatic report_test(input int num, input string name, input int base);
        $display("Test %0d %s: %0d errors", num, name, chk_errors + tb_errors - base);
    endtask

    // ================================================
    // Test sequence
    // ================================================
    initial begin
        int base;
        int n;
        int idx;
        int op;
        lfsr_q    = 16'd35;
        cfg_push  = 1'b0;
        cfg_data  = '0;
        start     = 1'b0;
        smp_val   = 1'b0;
        smp_data  = '0;
        res_sel   = '0;
        res_chk   = 1'b0;
        exp_data  = '0;
        full_chk  = 1'b0;
        exp_full  = 1'b0;
        tb_errors = 0;
        runs      = 0;
        wait (rst_n === 1'b1);
        @(negedge clk);

        // Random words, lengths 0..20, all opcodes
        base = chk_errors + tb_errors;
        for (int r = 0; r < RUNS_PER_TEST; r++) begin
            n = int'(rand_bits(3)) + 1;
            for (int k = 0; k < n; k++) begin
                push_word(make_word(rand_bits(2), rand_bits(2), rand_bits(8) % 21));
            end
            do_run(1'b0);
        end
        report_test(1, "random runs", base);

        // Nothing configured, one PE only, then all lengths zero
        base = chk_errors + tb_errors;
        do_run(1'b0);
        push_word(make_word(rand_bits(2), rand_bits(2), 7));
        do_run(1'b0);
        for (int p = 0; p < ccu_pkg::NUM_PE; p++) begin
            push_word(make_word(p, rand_bits(2), 0));
        end
        do_run(1'b0);
        report_test(2, "zero length and unconfigured PEs", base);

        // Second word for the same PE overrides the first
        base = chk_errors + tb_errors;
        for (int r = 0; r < 3; r++) begin
            idx = int'(rand_bits(2));
            op  = int'(rand_bits(2));
            push_word(make_word((idx + 1) % 4, rand_bits(2), rand_bits(8) % 21));
            push_word(make_word(idx, op, rand_bits(8) % 21));
            push_word(make_word(idx, (op + 1) % 4, 1 + rand_bits(8) % 20));
            do_run(1'b0);
        end
        report_test(3, "repeated PE config", base);

        // Words 9 and 10 target PE 0, which reads 0 if they are dropped
        base = chk_errors + tb_errors;
        for (int k = 0; k < 10; k++) begin
            if (k < ccu_pkg::FIFO_DEPTH) begin
                push_word(make_word(1 + rand_bits(8) % 3, rand_bits(2), rand_bits(8) % 21));
            end else begin
                push_word(make_word(0, ccu_pkg::OP_XOR, 20));
            end
        end
        do_run(1'b0);
        report_test(4, "FIFO full drop", base);

        // Long runs with a stray start while busy
        base = chk_errors + tb_errors;
        for (int r = 0; r < 2; r++) begin
            push_word(make_word(rand_bits(2), rand_bits(2), 12 + rand_bits(3)));
            do_run(1'b1);
        end
        report_test(5, "busy and done protocol", base);

        // One done per run and none from the stray starts
        if (done_count != runs) begin
            $display("Saw %0d done pulses over %0d runs", done_count, runs);
            tb_errors++;
        end
        $display("Runs %0d, checks %0d, errors %0d", runs, chk_checks, chk_errors + tb_errors);
        if (chk_errors + tb_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Simulation did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
src/ccu_pkg.sv
src/cfg_fifo.sv
src/ccu.sv
src/pe_cfg_regs.sv
src/pe_block.sv
src/pe_array_top.sv
testbench/tb_clk_gen.sv
testbench/tb_checker.sv
testbench/tb_top.sv
